/* source/dcache_pkg.sv */
// Data cache hit stage package with geometry, vector types, address split,
// port structs and the memory FSM and BIU command enums
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  // 64 KiB, 32-byte blocks, 2 ways, so 1024 sets
  localparam int XLEN          = 32;
  localparam int PLEN          = 32;
  localparam int BLK_BITS      = 256;
  localparam int BLK_OFFS_BITS = 5;
  localparam int DAT_OFFS_BITS = 3;
  localparam int IDX_BITS      = 10;
  localparam int TAG_BITS      = 17;
  localparam int WAYS          = 2;
  // Up to 3 outstanding BIU transfers
  localparam int INFLIGHT_BITS = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [XLEN/8-1:0]        wbe_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [BLK_BITS/8-1:0]    lbe_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] woffs_t;
  typedef logic [WAYS-1:0]          ways_t;
  typedef logic [INFLIGHT_BITS-1:0] inflight_t;
  typedef logic [PLEN-1:0]          paddr_t;

  // Physical address split, tag in the MSBs
  typedef struct packed {
    tag_t                                   tag;
    idx_t                                   idx;
    woffs_t                                 offs;
    logic [BLK_OFFS_BITS-DAT_OFFS_BITS-1:0] boffs;
  } dc_addr_t;

  // Request from the core memory stage
  typedef struct packed {
    logic     req;
    logic     wreq;
    logic     we;
    logic     cacheable;
    dc_addr_t adr;
    wbe_t     be;
    word_t    data;
  } core_req_t;

  // Pending write hit, be already at its line position
  typedef struct packed {
    idx_t   idx;
    woffs_t offs;
    word_t  data;
    lbe_t   be;
    ways_t  ways_hit;
  } wbuf_entry_t;

  // Victim line for the evict buffer
  typedef struct packed {
    paddr_t adr;
    line_t  line;
  } evict_entry_t;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ARMED,
    FLUSH,
    NONCACHEABLE,
    EVICT,
    FLUSHWAYS,
    WAIT4BIUCMD0,
    RECOVER
  } memfsm_state_t;

  typedef enum logic [1:0] {
    BIUCMD_NOP,
    BIUCMD_READWAY,
    BIUCMD_WRITEWAY
  } biucmd_t;

endpackage

`default_nettype wire

/* source/dcache_mem_ctrl.sv */
// Memory interface FSM of the data cache hit stage
// BIU command, status flags, stall and acknowledge
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_ctrl (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        flush_i,
  input  wire                        cacheflush_req_i,
  input  wire dcache_pkg::core_req_t core_req_i,
  input  wire                        cache_hit_i,
  input  wire                        cache_dirty_i,
  input  wire                        way_dirty_i,
  input  wire                        biucmd_ack_i,
  input  wire                        biucmd_busy_i,
  input  wire                        biucmd_nc_ack_i,
  input  wire dcache_pkg::inflight_t inflight_cnt_i,
  input  wire                        biu_stb_ack_i,
  input  wire                        biu_ack_i,
  input  wire                        biu_err_i,
  output logic                       stall_o,
  output logic                       ack_o,
  output logic                       armed_o,
  output logic                       flushing_o,
  output logic                       filling_o,
  output logic                       cacheflush_rdy_o,
  output dcache_pkg::biucmd_t        biucmd_o,
  output logic                       biucmd_nc_req_o,
  output logic                       fill_wait_o
);
  import dcache_pkg::*;

  memfsm_state_t state_q;
  logic          req_c;
  logic          req_nc;
  logic          cache_ack;
  logic          nc_done;

  // Request split by cacheability
  assign req_c     = core_req_i.req & core_req_i.cacheable;
  assign req_nc    = core_req_i.req & ~core_req_i.cacheable;
  assign cache_ack = req_c & cache_hit_i & ~flush_i;

  // Non-cacheable access ends on pipe flush, last transfer done,
  // or a new cacheable request once the BIU acks
  assign nc_done = flush_i ||
                   (!core_req_i.req && inflight_cnt_i == inflight_t'(1) && biu_ack_i) ||
                   (req_c && biu_ack_i);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q          <= ARMED;
      armed_o          <= 1'b1;
      flushing_o       <= 1'b0;
      filling_o        <= 1'b0;
      cacheflush_rdy_o <= 1'b1;
      biucmd_o         <= BIUCMD_NOP;
    end
    else
    begin
      case (state_q)
        ARMED:
        begin
          if (cacheflush_req_i && !core_req_i.we)
          begin
            state_q          <= FLUSH;
            armed_o          <= 1'b0;
            flushing_o       <= 1'b1;
            cacheflush_rdy_o <= 1'b0;
          end
          else if (req_nc && !flush_i)
          begin
            state_q <= NONCACHEABLE;
            armed_o <= 1'b0;
          end
          else if (req_c && !cache_hit_i && !flush_i && !biucmd_busy_i)
          begin
            // New line is read first, a dirty victim goes out afterwards
            state_q   <= way_dirty_i ? EVICT : WAIT4BIUCMD0;
            biucmd_o  <= BIUCMD_READWAY;
            armed_o   <= 1'b0;
            filling_o <= 1'b1;
          end
          else
          begin
            biucmd_o <= BIUCMD_NOP;
          end
        end
        FLUSH:
        begin
          // Dirty ways left in this set
          if (cache_dirty_i)
          begin
            state_q <= FLUSHWAYS;
          end
          else
          begin
            state_q          <= RECOVER;
            flushing_o       <= 1'b0;
            cacheflush_rdy_o <= 1'b1;
          end
        end
        FLUSHWAYS:
        begin
          // Write one dirty way, then rescan the set
          biucmd_o <= BIUCMD_WRITEWAY;
          if (biucmd_ack_i)
          begin
            state_q  <= FLUSH;
            biucmd_o <= BIUCMD_NOP;
          end
        end
        NONCACHEABLE:
        begin
          if (nc_done)
          begin
            state_q <= ARMED;
            armed_o <= 1'b1;
          end
        end
        EVICT:
        begin
          if (biucmd_ack_i || biu_err_i)
          begin
            state_q   <= RECOVER;
            biucmd_o  <= BIUCMD_WRITEWAY;
            filling_o <= 1'b0;
          end
        end
        WAIT4BIUCMD0:
        begin
          if (biucmd_ack_i || biu_err_i)
          begin
            state_q   <= RECOVER;
            biucmd_o  <= BIUCMD_NOP;
            filling_o <= 1'b0;
          end
        end
        default:
        begin
          // RECOVER, one cycle to reread tag and data memories
          state_q  <= ARMED;
          biucmd_o <= BIUCMD_NOP;
          armed_o  <= 1'b1;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // BIU request, stall and acknowledge
  ////////////////////////////////////////////////////////////////////////////

  assign biucmd_nc_req_o = (state_q == ARMED) & req_nc & ~flush_i;
  assign fill_wait_o     = (state_q == WAIT4BIUCMD0);

  always_comb
  begin
    case (state_q)
      ARMED:
        stall_o = (req_nc & (~biu_stb_ack_i | biucmd_busy_i)) | (req_c & ~cache_hit_i);
      NONCACHEABLE:
      begin
        // Idle core waits for outstanding transfers
        if (!core_req_i.req)
          stall_o = |inflight_cnt_i;
        else if (core_req_i.cacheable)
          stall_o = ~biu_ack_i;
        else
          stall_o = ~biu_stb_ack_i;
      end
      WAIT4BIUCMD0, EVICT, RECOVER:
        stall_o = ~(core_req_i.req & cache_hit_i);
      default:
        stall_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_o <= 1'b0;
    else if (state_q == NONCACHEABLE)
      ack_o <= biucmd_nc_ack_i;
    else if (state_q == FLUSH || state_q == FLUSHWAYS)
      ack_o <= 1'b0;
    else
      ack_o <= cache_ack;
  end

endmodule

`default_nettype wire

/* source/dcache_wbuf_capture.sv */
// Write hit capture for the write buffer with same-index bypass flag
`timescale 1ns/1ns
`default_nettype none

module dcache_wbuf_capture (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        flush_i,
  input  wire dcache_pkg::core_req_t core_req_i,
  input  wire                        cache_hit_i,
  input  wire dcache_pkg::ways_t     ways_hit_i,
  input  wire                        wbuf_ack_i,
  output logic                       wbuf_we_o,
  output dcache_pkg::wbuf_entry_t    wbuf_o,
  output logic                       bypass_o
);
  import dcache_pkg::*;

  logic                     wr_hit;
  logic [BLK_OFFS_BITS-1:0] be_pos;

  assign wr_hit = core_req_i.wreq & core_req_i.cacheable & cache_hit_i;
  // Byte position of the addressed word in the line
  assign be_pos = {core_req_i.adr.offs, 2'b00};

  // Flush wins, then a new hit, then the buffer ack
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wbuf_we_o <= 1'b0;
    else if (flush_i)
      wbuf_we_o <= 1'b0;
    else if (wr_hit)
      wbuf_we_o <= 1'b1;
    else if (wbuf_ack_i)
      wbuf_we_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_hit)
    begin
      wbuf_o.idx      <= core_req_i.adr.idx;
      wbuf_o.offs     <= core_req_i.adr.offs;
      wbuf_o.data     <= core_req_i.data;
      wbuf_o.be       <= lbe_t'(core_req_i.be) << be_pos;
      wbuf_o.ways_hit <= ways_hit_i;
    end
  end

  // Pending bytes not yet in the cache memory
  assign bypass_o = wbuf_we_o & (wbuf_o.idx == core_req_i.adr.idx);

endmodule

`default_nettype wire

/* source/dcache_evict_capture.sv */
// Victim address and line capture for the evict buffer
`timescale 1ns/1ns
`default_nettype none

module dcache_evict_capture (
  input  wire                        clk_i,
  input  wire                        armed_i,
  input  wire dcache_pkg::core_req_t core_req_i,
  input  wire dcache_pkg::tag_t      evict_tag_i,
  input  wire dcache_pkg::line_t     evict_line_i,
  output dcache_pkg::evict_entry_t   evict_o
);
  import dcache_pkg::*;

  // Victim tracks the set while armed
  // Held through fill and flush so the evict buffer sees a stable line
  always_ff @(posedge clk_i)
  begin
    if (armed_i)
    begin
      evict_o.adr  <= {evict_tag_i, core_req_i.adr.idx, {BLK_OFFS_BITS{1'b0}}};
      evict_o.line <= evict_line_i;
    end
  end

endmodule

`default_nettype wire

/* source/dcache_read_path.sv */
// Read path with write buffer merge, word select and read data register
`timescale 1ns/1ns
`default_nettype none

module dcache_read_path (
  input  wire                          clk_i,
  input  wire dcache_pkg::core_req_t   core_req_i,
  input  wire                          cache_hit_i,
  input  wire                          fill_wait_i,
  input  wire dcache_pkg::line_t       cache_line_i,
  input  wire dcache_pkg::wbuf_entry_t wbuf_i,
  input  wire                          bypass_i,
  input  wire dcache_pkg::word_t       biu_q_i,
  output dcache_pkg::word_t            q_o
);
  import dcache_pkg::*;

  line_t wbuf_line;
  line_t merged_line;
  word_t cache_q;

  // Buffered word copied to every word slot
  assign wbuf_line = {(BLK_BITS/XLEN){wbuf_i.data}};

  // Byte merge of pending write data
  always_comb
  begin
    for (int i = 0; i < BLK_BITS/8; i++)
    begin
      if (bypass_i && wbuf_i.be[i])
        merged_line[i*8 +: 8] = wbuf_line[i*8 +: 8];
      else
        merged_line[i*8 +: 8] = cache_line_i[i*8 +: 8];
    end
  end

  // Addressed word
  assign cache_q = merged_line[core_req_i.adr.offs * XLEN +: XLEN];

  // Cache word on a cacheable access or a hit during fill, else BIU data
  always_ff @(posedge clk_i)
  begin
    if (core_req_i.cacheable || (fill_wait_i && cache_hit_i))
      q_o <= cache_q;
    else
      q_o <= biu_q_i;
  end

endmodule

`default_nettype wire

/* source/dcache_hit_top.sv */
// Data cache hit stage top level
// Memory controller, write and evict capture, read path
`timescale 1ns/1ns
`default_nettype none

module dcache_hit_top (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  // Core side
  input  wire                           flush_i,
  input  wire                           cacheflush_req_i,
  input  wire dcache_pkg::core_req_t    core_req_i,
  output logic                          stall_o,
  output logic                          cacheflush_rdy_o,
  output logic                          armed_o,
  output logic                          flushing_o,
  output logic                          filling_o,
  output dcache_pkg::word_t             q_o,
  output logic                          ack_o,
  // Cache memories
  input  wire                           cache_hit_i,
  input  wire dcache_pkg::ways_t        ways_hit_i,
  input  wire dcache_pkg::line_t        cache_line_i,
  input  wire                           cache_dirty_i,
  input  wire                           way_dirty_i,
  output dcache_pkg::idx_t              idx_o,
  output dcache_pkg::tag_t              core_tag_o,
  // Write buffer
  output logic                          wbuf_we_o,
  output dcache_pkg::wbuf_entry_t       wbuf_o,
  input  wire                           wbuf_ack_i,
  // Evict buffer
  input  wire dcache_pkg::tag_t         evict_tag_i,
  input  wire dcache_pkg::line_t        evict_line_i,
  output dcache_pkg::evict_entry_t      evict_o,
  // BIU
  output dcache_pkg::biucmd_t           biucmd_o,
  input  wire                           biucmd_ack_i,
  input  wire                           biucmd_busy_i,
  output logic                          biucmd_nc_req_o,
  input  wire                           biucmd_nc_ack_i,
  input  wire dcache_pkg::inflight_t    inflight_cnt_i,
  input  wire dcache_pkg::word_t        biu_q_i,
  input  wire                           biu_stb_ack_i,
  input  wire                           biu_ack_i,
  input  wire                           biu_err_i
);
  import dcache_pkg::*;

  // Controller to read path
  logic fill_wait;
  // Held write hit matches current index
  logic wbuf_bypass;

  // Tag and index for the tag and data memories
  assign idx_o      = core_req_i.adr.idx;
  assign core_tag_o = core_req_i.adr.tag;

  dcache_mem_ctrl u_mem_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .cacheflush_req_i (cacheflush_req_i),
    .core_req_i       (core_req_i),
    .cache_hit_i      (cache_hit_i),
    .cache_dirty_i    (cache_dirty_i),
    .way_dirty_i      (way_dirty_i),
    .biucmd_ack_i     (biucmd_ack_i),
    .biucmd_busy_i    (biucmd_busy_i),
    .biucmd_nc_ack_i  (biucmd_nc_ack_i),
    .inflight_cnt_i   (inflight_cnt_i),
    .biu_stb_ack_i    (biu_stb_ack_i),
    .biu_ack_i        (biu_ack_i),
    .biu_err_i        (biu_err_i),
    .stall_o          (stall_o),
    .ack_o            (ack_o),
    .armed_o          (armed_o),
    .flushing_o       (flushing_o),
    .filling_o        (filling_o),
    .cacheflush_rdy_o (cacheflush_rdy_o),
    .biucmd_o         (biucmd_o),
    .biucmd_nc_req_o  (biucmd_nc_req_o),
    .fill_wait_o      (fill_wait)
  );

  dcache_wbuf_capture u_wbuf_capture (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .core_req_i  (core_req_i),
    .cache_hit_i (cache_hit_i),
    .ways_hit_i  (ways_hit_i),
    .wbuf_ack_i  (wbuf_ack_i),
    .wbuf_we_o   (wbuf_we_o),
    .wbuf_o      (wbuf_o),
    .bypass_o    (wbuf_bypass)
  );

  // Armed level doubles as the evict capture enable
  dcache_evict_capture u_evict_capture (
    .clk_i        (clk_i),
    .armed_i      (armed_o),
    .core_req_i   (core_req_i),
    .evict_tag_i  (evict_tag_i),
    .evict_line_i (evict_line_i),
    .evict_o      (evict_o)
  );

  dcache_read_path u_read_path (
    .clk_i        (clk_i),
    .core_req_i   (core_req_i),
    .cache_hit_i  (cache_hit_i),
    .fill_wait_i  (fill_wait),
    .cache_line_i (cache_line_i),
    .wbuf_i       (wbuf_o),
    .bypass_i     (wbuf_bypass),
    .biu_q_i      (biu_q_i),
    .q_o          (q_o)
  );

endmodule

`default_nettype wire

/* tb/dcache_hit_cases.svh */
// Stimulus and expected-value rows for the data cache hit stage testbench
// Inputs  req wreq cacheable hit way_dirty cache_dirty flush_req wbuf_ack cmd_ack biu_ack
//         offs inflight
// Expect  stall armed filling flushing flush_rdy ack wbuf_we nc_req biucmd q_chk x_chk

// Idle, then read hit
rows[0]  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[1]  = '{1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 3, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[2]  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 1, 0};
// Write hit, same-index read with merge, buffer ack
rows[3]  = '{1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 2, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[4]  = '{1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 2, 0, 0, 1, 0, 0, 1, 1, 1, 0, 0, 0, 1};
rows[5]  = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1, 1, 0, 0, 2, 0};
rows[6]  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
// Clean miss with line fill
rows[7]  = '{1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 5, 0, 1, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[8]  = '{1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 5, 0, 1, 0, 1, 0, 1, 0, 0, 0, 1, 0, 0};
rows[9]  = '{1, 0, 1, 0, 0, 0, 0, 0, 1, 0, 5, 0, 1, 0, 1, 0, 1, 0, 0, 0, 1, 0, 0};
rows[10] = '{1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 5, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[11] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 1, 0};
// Dirty miss with eviction
rows[12] = '{1, 0, 1, 0, 1, 0, 0, 0, 0, 0, 1, 0, 1, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[13] = '{1, 0, 1, 0, 1, 0, 0, 0, 0, 0, 1, 0, 1, 0, 1, 0, 1, 0, 0, 0, 1, 0, 2};
rows[14] = '{1, 0, 1, 0, 1, 0, 0, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 0, 0, 1, 0, 0};
rows[15] = '{1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0, 0, 0, 2, 0, 0};
rows[16] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 1, 0};
// Non-cacheable read
rows[17] = '{1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 1, 0, 0, 0};
rows[18] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 1, 0, 0, 0, 1, 0, 0, 0, 0, 3, 0};
rows[19] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 3, 0};
// Cache flush of one dirty way, cleaned by the time the BIU acks
rows[20] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[21] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0};
rows[22] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0};
rows[23] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 2, 0, 0};
rows[24] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0};
rows[25] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0};
rows[26] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0};

/* tb/dcache_hit_tb.sv */
// Testbench for the data cache hit stage
// Clock, reset, watchdog, table-driven stimulus loop and output checks
`timescale 1ns/1ns
`default_nettype none

module dcache_hit_tb;
  import dcache_pkg::*;

  localparam int NROWS = 27;
  localparam idx_t  TB_IDX  = 10'h155;
  localparam tag_t  TB_TAG  = 17'h0_1234;
  localparam wbe_t  TB_BE   = 4'b0101;
  localparam word_t TB_DATA = 32'ha5c3_1e77;

  // One cycle of stimulus and expected outputs
  typedef struct {
    logic req, wreq, cacheable, hit, wdirty, cdirty, flreq, wack, cmdack, biuack;
    logic [2:0] offs;
    logic [1:0] inflight;
    logic stall, armed, filling, flushing, rdy, ack, wbuf_we, nc_req;
    logic [1:0] cmd;
    // 1 cache word, 2 merged word, 3 BIU word of the row before
    logic [1:0] qchk;
    // 1 write buffer entry, 2 evict entry
    logic [1:0] xchk;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic         flush, cacheflush_req, cache_hit, cache_dirty, way_dirty, wbuf_ack;
  logic         biucmd_ack, biucmd_busy, biucmd_nc_ack, biu_stb_ack, biu_ack, biu_err;
  core_req_t    core_req;
  ways_t        ways_hit;
  line_t        cache_line;
  tag_t         evict_tag;
  line_t        evict_line;
  inflight_t    inflight_cnt;
  word_t        biu_q;
  logic         stall, cacheflush_rdy, armed, flushing, filling, ack, wbuf_we, nc_req;
  word_t        q;
  idx_t         idx;
  tag_t         core_tag;
  wbuf_entry_t  wbuf;
  evict_entry_t evict;
  biucmd_t      biucmd;

  row_t         rows [NROWS];
  line_t        lines [NROWS];
  word_t        biu_words [NROWS];
  logic [31:0]  rnd;

  dcache_hit_top dcache_hit_top_inst (
    .clk_i (clk), .rst_ni (rst_n), .flush_i (flush), .cacheflush_req_i (cacheflush_req),
    .core_req_i (core_req), .stall_o (stall), .cacheflush_rdy_o (cacheflush_rdy),
    .armed_o (armed), .flushing_o (flushing), .filling_o (filling), .q_o (q),
    .ack_o (ack), .cache_hit_i (cache_hit), .ways_hit_i (ways_hit),
    .cache_line_i (cache_line), .cache_dirty_i (cache_dirty), .way_dirty_i (way_dirty),
    .idx_o (idx), .core_tag_o (core_tag), .wbuf_we_o (wbuf_we), .wbuf_o (wbuf),
    .wbuf_ack_i (wbuf_ack), .evict_tag_i (evict_tag), .evict_line_i (evict_line),
    .evict_o (evict), .biucmd_o (biucmd), .biucmd_ack_i (biucmd_ack),
    .biucmd_busy_i (biucmd_busy), .biucmd_nc_req_o (nc_req),
    .biucmd_nc_ack_i (biucmd_nc_ack), .inflight_cnt_i (inflight_cnt), .biu_q_i (biu_q),
    .biu_stb_ack_i (biu_stb_ack), .biu_ack_i (biu_ack), .biu_err_i (biu_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Rows plus reset plus margin
  initial
  begin
    #((NROWS + 10 + 20) * 10);
    $display("Timeout: table loop did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare(input string name, input logic [287:0] got,
                         input logic [287:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // Word of a line with the buffered bytes written over it
  function automatic word_t merged_word(input line_t l, input int offs);
    word_t w;
    w = l[offs*32 +: 32];
    for (int b = 0; b < 4; b++)
    begin
      if (TB_BE[b])
        w[b*8 +: 8] = TB_DATA[b*8 +: 8];
    end
    return w;
  endfunction

  task automatic drive(input int r);
    core_req.req       = rows[r].req;
    core_req.wreq      = rows[r].wreq;
    core_req.we        = rows[r].wreq;
    core_req.cacheable = rows[r].cacheable;
    core_req.adr.offs  = rows[r].offs;
    cache_hit          = rows[r].hit;
    ways_hit           = rows[r].hit ? 2'b01 : 2'b00;
    way_dirty          = rows[r].wdirty;
    cache_dirty        = rows[r].cdirty;
    cacheflush_req     = rows[r].flreq;
    wbuf_ack           = rows[r].wack;
    biucmd_ack         = rows[r].cmdack;
    biu_ack            = rows[r].biuack;
    biucmd_nc_ack      = rows[r].biuack;
    inflight_cnt       = rows[r].inflight;
    cache_line         = lines[r];
    biu_q              = biu_words[r];
  endtask

  task automatic check_row(input int r);
    int p;
    p = (r > 0) ? r - 1 : 0;
    compare("stall_o", stall, rows[r].stall);
    compare("armed_o", armed, rows[r].armed);
    compare("filling_o", filling, rows[r].filling);
    compare("flushing_o", flushing, rows[r].flushing);
    compare("cacheflush_rdy_o", cacheflush_rdy, rows[r].rdy);
    compare("ack_o", ack, rows[r].ack);
    compare("wbuf_we_o", wbuf_we, rows[r].wbuf_we);
    compare("biucmd_nc_req_o", nc_req, rows[r].nc_req);
    compare("biucmd_o", biucmd, rows[r].cmd);
    compare("idx_o", idx, TB_IDX);
    compare("core_tag_o", core_tag, TB_TAG);
    case (rows[r].qchk)
      2'd1: compare("q_o", q, lines[p][rows[p].offs*32 +: 32]);
      2'd2: compare("q_o", q, merged_word(lines[p], rows[p].offs));
      2'd3: compare("q_o", q, biu_words[p]);
      default: ;
    endcase
    if (rows[r].xchk == 2'd1)
    begin
      compare("wbuf_o.idx", wbuf.idx, TB_IDX);
      compare("wbuf_o.offs", wbuf.offs, rows[p].offs);
      compare("wbuf_o.data", wbuf.data, TB_DATA);
      compare("wbuf_o.be", wbuf.be, lbe_t'(TB_BE) << (rows[p].offs * 4));
      compare("wbuf_o.ways_hit", wbuf.ways_hit, 2'b01);
    end
    else if (rows[r].xchk == 2'd2)
    begin
      compare("evict_o.adr", evict.adr, {evict_tag, TB_IDX, 5'b0});
      compare("evict_o.line", evict.line, evict_line);
    end
  endtask

  initial
  begin
    `include "dcache_hit_cases.svh"
    rnd = 32'h4573_44da;
    for (int r = 0; r < NROWS; r++)
    begin
      for (int w = 0; w < 8; w++)
      begin
        rnd = xorshift(rnd);
        lines[r][w*32 +: 32] = rnd;
      end
      rnd = xorshift(rnd);
      biu_words[r] = rnd;
    end
    rnd        = xorshift(rnd);
    evict_tag  = rnd[16:0];
    for (int w = 0; w < 8; w++)
    begin
      rnd = xorshift(rnd);
      evict_line[w*32 +: 32] = rnd;
    end
    // All inputs idle under reset
    rst_n       = 1'b0;
    flush       = 1'b0;
    biucmd_busy = 1'b0;
    biu_stb_ack = 1'b1;
    biu_err     = 1'b0;
    core_req    = '0;
    core_req.adr.idx = TB_IDX;
    core_req.adr.tag = TB_TAG;
    core_req.be      = TB_BE;
    core_req.data    = TB_DATA;
    drive(0);
    repeat (10) @(posedge clk);
    compare("armed_o", armed, 1'b1);
    compare("cacheflush_rdy_o", cacheflush_rdy, 1'b1);
    compare("filling_o", filling, 1'b0);
    compare("flushing_o", flushing, 1'b0);
    compare("biucmd_o", biucmd, BIUCMD_NOP);
    compare("ack_o", ack, 1'b0);
    compare("wbuf_we_o", wbuf_we, 1'b0);
    #1 rst_n = 1'b1;
    for (int r = 0; r < NROWS; r++)
    begin
      @(posedge clk);
      #1 drive(r);
      #8 check_row(r);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
source/dcache_pkg.sv
source/dcache_mem_ctrl.sv
source/dcache_wbuf_capture.sv
source/dcache_evict_capture.sv
source/dcache_read_path.sv
source/dcache_hit_top.sv
tb/dcache_hit_tb.sv
